// ==== common/build_config_pkg.sv ====
// Instruction cache configuration types
package build_config_pkg;

  // maximum geometry the tag store is sized for
  localparam int unsigned MAX_SETS       = 64;
  localparam int unsigned MAX_WAYS       = 4;
  localparam int unsigned MAX_LINE_BYTES = 64;
  localparam int unsigned MIN_LINE_BYTES = 4;
  localparam int unsigned PLEN           = 32;

  typedef logic [15:0] byte_size_t;
  typedef logic [2:0]  assoc_t;
  typedef logic [7:0]  line_bytes_t;
  typedef logic [5:0]  width_t;

  typedef struct packed {
    byte_size_t  icache_byte_size;
    assoc_t      icache_set_assoc;
    line_bytes_t icache_line_width;
  } user_cfg_t;

  typedef struct packed {
    byte_size_t  icache_byte_size;
    assoc_t      icache_set_assoc;
    line_bytes_t icache_line_width;
    width_t      way_width;
    width_t      offset_width;
    width_t      index_width;
    width_t      tag_width;
  } cfg_t;

  // position of the highest set bit, zero for zero
  function automatic width_t log2_floor(input byte_size_t value);
    width_t result;
    result = '0;
    for (int i = 0; i < $bits(byte_size_t); i++) begin
      if (value[i]) begin
        result = width_t'(i);
      end
    end
    return result;
  endfunction

  // sets = bytes / (ways * line bytes), exact when both are powers of two
  function automatic byte_size_t set_count(input user_cfg_t ucfg);
    width_t shift;
    shift = log2_floor(byte_size_t'(ucfg.icache_set_assoc))
          + log2_floor(byte_size_t'(ucfg.icache_line_width));
    return ucfg.icache_byte_size >> shift;
  endfunction

  function automatic cfg_t build_config(input user_cfg_t ucfg);
    cfg_t cfg;
    cfg.icache_byte_size  = ucfg.icache_byte_size;
    cfg.icache_set_assoc  = ucfg.icache_set_assoc;
    cfg.icache_line_width = ucfg.icache_line_width;
    cfg.way_width         = log2_floor(byte_size_t'(ucfg.icache_set_assoc));
    cfg.offset_width      = log2_floor(byte_size_t'(ucfg.icache_line_width));
    cfg.index_width       = log2_floor(set_count(ucfg));
    cfg.tag_width         = width_t'(PLEN) - cfg.index_width - cfg.offset_width;
    return cfg;
  endfunction

  // 1 KiB, 2 ways, 16-byte lines
  localparam user_cfg_t DEFAULT_USER_CFG = '{
    icache_byte_size:  16'd1024,
    icache_set_assoc:  3'd2,
    icache_line_width: 8'd16
  };
  localparam cfg_t DEFAULT_CFG = build_config(DEFAULT_USER_CFG);

endpackage

// ==== common/fetch_pkg.sv ====
// Fetch path types
package fetch_pkg;

  localparam int unsigned IBUF_DEPTH = 4;

  // physical address and pc
  typedef logic [build_config_pkg::PLEN-1:0] paddr_t;

  // widest possible tag, upper bits zero for shorter tags
  typedef logic [31:0] tag_t;

  // set index and way select at maximum geometry
  typedef logic [$clog2(build_config_pkg::MAX_SETS)-1:0] idx_t;
  typedef logic [$clog2(build_config_pkg::MAX_WAYS)-1:0] way_t;

  // queue pointers and occupancy
  typedef logic [$clog2(IBUF_DEPTH)-1:0]   ibuf_ptr_t;
  typedef logic [$clog2(IBUF_DEPTH+1)-1:0] ibuf_cnt_t;

  typedef struct packed {
    paddr_t pc;
    paddr_t pred_npc;
  } fetch_req_t;

  typedef struct packed {
    logic   slot_valid;
    paddr_t pc;
    paddr_t pred_npc;
    way_t   way;
  } ibuf_entry_t;

endpackage

// ==== design/cfg_builder.sv ====
// Cache configuration register
`timescale 1ns/1ps

module cfg_builder (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_cfg_load,
  input  build_config_pkg::user_cfg_t  i_user_cfg,
  output build_config_pkg::cfg_t       o_cfg,
  output logic                         o_cfg_err,
  output logic                         o_cfg_new
);

  build_config_pkg::cfg_t     cfg_q;
  build_config_pkg::cfg_t     cfg_next;
  build_config_pkg::byte_size_t sets;
  logic                       ways_ok;
  logic                       line_ok;
  logic                       sets_ok;
  logic                       cfg_legal;

  function automatic logic is_pow2(input logic [15:0] value);
    return (value != 16'd0) && ((value & (value - 16'd1)) == 16'd0);
  endfunction

  assign cfg_next = build_config_pkg::build_config(i_user_cfg);
  assign sets     = build_config_pkg::set_count(i_user_cfg);

  // legality of the requested geometry
  assign ways_ok = is_pow2(16'(i_user_cfg.icache_set_assoc))
                && (i_user_cfg.icache_set_assoc <= build_config_pkg::MAX_WAYS);
  assign line_ok = is_pow2(16'(i_user_cfg.icache_line_width))
                && (i_user_cfg.icache_line_width >= build_config_pkg::MIN_LINE_BYTES)
                && (i_user_cfg.icache_line_width <= build_config_pkg::MAX_LINE_BYTES);
  assign sets_ok = (sets != '0) && (sets <= build_config_pkg::MAX_SETS);
  assign cfg_legal = ways_ok && line_ok && sets_ok;

  // lets the tag store flush on the same edge the new geometry lands
  assign o_cfg_new = i_cfg_load && cfg_legal;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cfg_q     <= build_config_pkg::DEFAULT_CFG;
      o_cfg_err <= 1'b0;
    end else if (i_cfg_load) begin
      // error flag follows the most recent load
      o_cfg_err <= !cfg_legal;
      if (cfg_legal) begin
        cfg_q <= cfg_next;
      end
    end
  end

  assign o_cfg = cfg_q;

endmodule

// ==== icache/icache_tags.sv ====
// Instruction cache tag store
`timescale 1ns/1ps

module icache_tags (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  build_config_pkg::cfg_t    i_cfg,
  input  logic                      i_cfg_new,
  input  logic                      i_fetch_valid,
  input  fetch_pkg::fetch_req_t     i_fetch,
  input  logic                      i_refill_valid,
  input  fetch_pkg::paddr_t         i_refill_addr,
  output logic                      o_hit_valid,
  output fetch_pkg::ibuf_entry_t    o_hit_entry,
  output logic                      o_miss,
  output fetch_pkg::paddr_t         o_miss_addr
);

  localparam int unsigned SETS = build_config_pkg::MAX_SETS;
  localparam int unsigned WAYS = build_config_pkg::MAX_WAYS;

  fetch_pkg::tag_t       tag_q   [SETS][WAYS];
  logic [WAYS-1:0]       valid_q [SETS];
  fetch_pkg::way_t       victim_q;
  fetch_pkg::way_t       way_mask;

  fetch_pkg::idx_t       lk_idx;
  fetch_pkg::tag_t       lk_tag;
  logic                  lk_hit;
  fetch_pkg::way_t       lk_way;
  fetch_pkg::idx_t       rf_idx;
  fetch_pkg::tag_t       rf_tag;
  fetch_pkg::paddr_t     line_mask;

  // lookup result stage
  logic                  fetch_q;
  logic                  hit_q;
  fetch_pkg::fetch_req_t req_q;
  fetch_pkg::way_t       way_q;
  fetch_pkg::paddr_t     line_q;

  function automatic fetch_pkg::idx_t addr_index(input fetch_pkg::paddr_t addr,
                                                 input build_config_pkg::cfg_t cfg);
    fetch_pkg::paddr_t mask;
    mask = (32'd1 << cfg.index_width) - 32'd1;
    return fetch_pkg::idx_t'((addr >> cfg.offset_width) & mask);
  endfunction

  function automatic fetch_pkg::tag_t addr_tag(input fetch_pkg::paddr_t addr,
                                               input build_config_pkg::cfg_t cfg);
    return fetch_pkg::tag_t'(addr >> (cfg.offset_width + cfg.index_width));
  endfunction

  assign lk_idx    = addr_index(i_fetch.pc, i_cfg);
  assign lk_tag    = addr_tag(i_fetch.pc, i_cfg);
  assign rf_idx    = addr_index(i_refill_addr, i_cfg);
  assign rf_tag    = addr_tag(i_refill_addr, i_cfg);
  assign line_mask = ~((32'd1 << i_cfg.offset_width) - 32'd1);
  assign way_mask  = fetch_pkg::way_t'((32'd1 << i_cfg.way_width) - 32'd1);

  // only the active ways take part, first match wins
  always_comb begin
    lk_hit = 1'b0;
    lk_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (!lk_hit && (w < int'(i_cfg.icache_set_assoc))
          && valid_q[lk_idx][w] && (tag_q[lk_idx][w] == lk_tag)) begin
        lk_hit = 1'b1;
        lk_way = fetch_pkg::way_t'(w);
      end
    end
  end

  // a new configuration flushes everything and takes priority over refill
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q  <= '{default: '0};
      victim_q <= '0;
    end else if (i_cfg_new) begin
      valid_q  <= '{default: '0};
      victim_q <= '0;
    end else if (i_refill_valid) begin
      valid_q[rf_idx][victim_q] <= 1'b1;
      victim_q                  <= (victim_q + 2'd1) & way_mask;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_refill_valid && !i_cfg_new) begin
      tag_q[rf_idx][victim_q] <= rf_tag;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fetch_q <= 1'b0;
      hit_q   <= 1'b0;
    end else begin
      fetch_q <= i_fetch_valid;
      hit_q   <= lk_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fetch_valid) begin
      req_q  <= i_fetch;
      way_q  <= lk_way;
      line_q <= i_fetch.pc & line_mask;
    end
  end

  assign o_hit_valid = fetch_q && hit_q;
  assign o_miss      = fetch_q && !hit_q;
  assign o_miss_addr = line_q;
  assign o_hit_entry = '{
    slot_valid: o_hit_valid,
    pc:         req_q.pc,
    pred_npc:   req_q.pred_npc,
    way:        way_q
  };

endmodule

// ==== ibuf/inst_buffer.sv ====
// Instruction buffer queue
`timescale 1ns/1ps

module inst_buffer (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_push,
  input  fetch_pkg::ibuf_entry_t  i_entry,
  input  logic                    i_pop,
  output fetch_pkg::ibuf_entry_t  o_head,
  output logic                    o_full,
  output logic                    o_empty,
  output logic                    o_drop
);

  localparam int unsigned DEPTH = fetch_pkg::IBUF_DEPTH;

  fetch_pkg::ibuf_entry_t mem_q [DEPTH];
  fetch_pkg::ibuf_ptr_t   wr_ptr_q;
  fetch_pkg::ibuf_ptr_t   rd_ptr_q;
  fetch_pkg::ibuf_cnt_t   count_q;
  logic                   pop_ok;
  logic                   push_ok;

  assign o_full  = (count_q == fetch_pkg::ibuf_cnt_t'(DEPTH));
  assign o_empty = (count_q == '0);

  // a pop on a full queue makes room for the push in the same cycle
  assign pop_ok  = i_pop && !o_empty;
  assign push_ok = i_push && (!o_full || pop_ok);
  assign o_drop  = i_push && !push_ok;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= i_entry;
    end
  end

  // empty slots never show stale contents
  assign o_head = o_empty ? '0 : mem_q[rd_ptr_q];

endmodule

// ==== design/fetch_top.sv ====
// Instruction fetch front end
`timescale 1ns/1ps

module fetch_top (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_cfg_load,
  input  build_config_pkg::user_cfg_t  i_user_cfg,
  input  logic                         i_fetch_valid,
  input  fetch_pkg::fetch_req_t        i_fetch,
  input  logic                         i_refill_valid,
  input  fetch_pkg::paddr_t            i_refill_addr,
  input  logic                         i_ibuf_pop,
  output build_config_pkg::cfg_t       o_cfg,
  output logic                         o_cfg_err,
  output logic                         o_miss,
  output fetch_pkg::paddr_t            o_miss_addr,
  output logic                         o_drop,
  output fetch_pkg::ibuf_entry_t       o_ibuf_head,
  output logic                         o_ibuf_full,
  output logic                         o_ibuf_empty
);

  logic                   cfg_new;
  logic                   hit_valid;
  fetch_pkg::ibuf_entry_t hit_entry;

  cfg_builder cfg_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cfg_load (i_cfg_load),
    .i_user_cfg (i_user_cfg),
    .o_cfg      (o_cfg),
    .o_cfg_err  (o_cfg_err),
    .o_cfg_new  (cfg_new)
  );

  // geometry comes from the live configuration
  icache_tags tags_i (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_cfg          (o_cfg),
    .i_cfg_new      (cfg_new),
    .i_fetch_valid  (i_fetch_valid),
    .i_fetch        (i_fetch),
    .i_refill_valid (i_refill_valid),
    .i_refill_addr  (i_refill_addr),
    .o_hit_valid    (hit_valid),
    .o_hit_entry    (hit_entry),
    .o_miss         (o_miss),
    .o_miss_addr    (o_miss_addr)
  );

  // hits go straight into the queue
  inst_buffer ibuf_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (hit_valid),
    .i_entry (hit_entry),
    .i_pop   (i_ibuf_pop),
    .o_head  (o_ibuf_head),
    .o_full  (o_ibuf_full),
    .o_empty (o_ibuf_empty),
    .o_drop  (o_drop)
  );

endmodule

// ==== verification/fetch_top_props.sv ====
// Fetch front end properties
`timescale 1ns/1ps

module fetch_top_props (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_cfg_load,
  input logic i_cfg_err,
  input logic i_miss,
  input logic i_drop,
  input logic i_ibuf_full,
  input logic i_ibuf_empty
);

  // a dropped entry always comes from a hit
  miss_drop_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_miss && i_drop))
    else $error("miss and drop were high in the same cycle");

  full_empty_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_ibuf_full && i_ibuf_empty))
    else $error("instruction buffer was full and empty at once");

  // error flag only moves on a load
  cfg_err_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_cfg_err) |-> $past(i_cfg_load))
    else $error("configuration error rose without a load in the cycle before");

endmodule

bind fetch_top fetch_top_props props_i (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_cfg_load   (i_cfg_load),
  .i_cfg_err    (o_cfg_err),
  .i_miss       (o_miss),
  .i_drop       (o_drop),
  .i_ibuf_full  (o_ibuf_full),
  .i_ibuf_empty (o_ibuf_empty)
);

// ==== verification/tb_fetch_top.sv ====
// Fetch front end testbench
`timescale 1ns/1ps

module tb_fetch_top;

  localparam int REC_WORDS  = 6;
  localparam int MAX_RECS   = 40;
  localparam int WAIT_LIMIT = 16;

  // trace opcodes
  localparam logic [31:0] OP_IDLE   = 32'h0;
  localparam logic [31:0] OP_LOAD   = 32'h1;
  localparam logic [31:0] OP_FETCH  = 32'h2;
  localparam logic [31:0] OP_REFILL = 32'h3;
  localparam logic [31:0] OP_POP    = 32'h4;
  localparam logic [31:0] OP_WAIT   = 32'h5;
  localparam logic [31:0] OP_STATUS = 32'h6;
  localparam logic [31:0] OP_END    = 32'hf;

  logic                        clk;
  logic                        rst_n;
  logic                        cfg_load;
  build_config_pkg::user_cfg_t user_cfg;
  logic                        fetch_valid;
  fetch_pkg::fetch_req_t       fetch_req;
  logic                        refill_valid;
  fetch_pkg::paddr_t           refill_addr;
  logic                        ibuf_pop;
  build_config_pkg::cfg_t      cfg;
  logic                        cfg_err;
  logic                        miss;
  fetch_pkg::paddr_t           miss_addr;
  logic                        drop;
  fetch_pkg::ibuf_entry_t      ibuf_head;
  logic                        ibuf_full;
  logic                        ibuf_empty;

  logic [31:0] trace_mem [MAX_RECS*REC_WORDS];
  int          value_errs;
  int          other_errs;
  int          rec;
  bit          trace_done;

  fetch_top dut_i (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_cfg_load     (cfg_load),
    .i_user_cfg     (user_cfg),
    .i_fetch_valid  (fetch_valid),
    .i_fetch        (fetch_req),
    .i_refill_valid (refill_valid),
    .i_refill_addr  (refill_addr),
    .i_ibuf_pop     (ibuf_pop),
    .o_cfg          (cfg),
    .o_cfg_err      (cfg_err),
    .o_miss         (miss),
    .o_miss_addr    (miss_addr),
    .o_drop         (drop),
    .o_ibuf_head    (ibuf_head),
    .o_ibuf_full    (ibuf_full),
    .o_ibuf_empty   (ibuf_empty)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error rec %0d %s: expected %h, actual %h", rec, name, expected, actual);
      value_errs++;
    end
  endtask

  // flag order cfg_err, empty, full, drop, miss
  task automatic check_flags(input string name, input logic [4:0] expected,
                             input logic [4:0] mask);
    check_value({name, " flags"}, 32'(expected & mask),
                32'({cfg_err, ibuf_empty, ibuf_full, drop, miss} & mask));
  endtask

  // widths one per byte, user fields right aligned
  task automatic check_cfg(input string name, input logic [31:0] exp_widths,
                           input logic [31:0] exp_user);
    check_value({name, " widths"}, exp_widths,
                {2'b00, cfg.way_width, 2'b00, cfg.offset_width,
                 2'b00, cfg.index_width, 2'b00, cfg.tag_width});
    check_value({name, " user"}, exp_user,
                {5'b0, cfg.icache_byte_size, cfg.icache_set_assoc, cfg.icache_line_width});
  endtask

  task automatic wait_for_empty();
    int cycles;
    cycles = 0;
    while (!ibuf_empty && cycles < WAIT_LIMIT) begin
      step_cycle();
      cycles++;
    end
    assert (ibuf_empty) else begin
      $display("timeout at rec %0d: instruction buffer never became empty", rec);
      other_errs++;
    end
  endtask

  task automatic run_record(input int base);
    logic [31:0] op;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    logic [31:0] exp_c;
    logic [31:0] exp_d;
    logic [31:0] exp_e;
    op    = trace_mem[base];
    arg_a = trace_mem[base+1];
    arg_b = trace_mem[base+2];
    exp_c = trace_mem[base+3];
    exp_d = trace_mem[base+4];
    exp_e = trace_mem[base+5];
    case (op)
      OP_IDLE: step_cycle();
      OP_LOAD: begin
        cfg_load = 1'b1;
        user_cfg = build_config_pkg::user_cfg_t'(arg_a[26:0]);
        step_cycle();
        cfg_load = 1'b0;
        check_flags("load", exp_c[4:0], 5'b10000);
        check_cfg("load", exp_d, exp_e);
      end
      OP_FETCH: begin
        fetch_valid        = 1'b1;
        fetch_req.pc       = arg_a;
        fetch_req.pred_npc = arg_b;
        step_cycle();
        fetch_valid = 1'b0;
        check_flags("fetch", exp_c[4:0], 5'b00011);
        if (exp_c[0]) begin
          check_value("fetch miss_addr", exp_d, miss_addr);
        end
      end
      OP_REFILL: begin
        refill_valid = 1'b1;
        refill_addr  = arg_a;
        step_cycle();
        refill_valid = 1'b0;
      end
      OP_POP: begin
        // head seen before the edge that removes it
        check_value("pop slot_valid", 32'd1, 32'(ibuf_head.slot_valid));
        check_value("pop way", exp_c, 32'(ibuf_head.way));
        check_value("pop pc", exp_d, ibuf_head.pc);
        check_value("pop pred_npc", exp_e, ibuf_head.pred_npc);
        ibuf_pop = 1'b1;
        step_cycle();
        ibuf_pop = 1'b0;
      end
      OP_WAIT: wait_for_empty();
      OP_STATUS: begin
        step_cycle();
        check_flags("status", exp_c[4:0], 5'b11111);
        check_value("status slot_valid", 32'(!exp_c[3]), 32'(ibuf_head.slot_valid));
        check_cfg("status", exp_d, exp_e);
      end
      OP_END: trace_done = 1'b1;
      default: begin
        $display("trace rec %0d holds an unknown opcode %h", rec, op);
        other_errs++;
        trace_done = 1'b1;
      end
    endcase
  endtask

  initial begin
    rst_n        = 1'b0;
    cfg_load     = 1'b0;
    user_cfg     = '0;
    fetch_valid  = 1'b0;
    fetch_req    = '0;
    refill_valid = 1'b0;
    refill_addr  = '0;
    ibuf_pop     = 1'b0;
    value_errs   = 0;
    other_errs   = 0;
    rec          = 0;
    trace_done   = 1'b0;
    $readmemh("verification/fetch_trace.txt", trace_mem);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    while (!trace_done && rec < MAX_RECS) begin
      run_record(rec * REC_WORDS);
      rec++;
    end
    if (!trace_done) begin
      $display("trace ran past %0d records without an end marker", MAX_RECS);
      other_errs++;
    end
    $display("%0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verification/fetch_trace.txt ====
// columns: op arg_a arg_b exp_c exp_d exp_e, ops 0 idle 1 load 2 fetch 3 refill 4 pop 5 wait 6 status f end
// exp_c flags bit0 miss bit1 drop bit2 full bit3 empty bit4 cfg_err, or the head way for a pop
// exp_d widths way/offset/index/tag one per byte, miss address or head pc; exp_e user cfg or head npc
00000006 00000000 00000000 00000008 01040517 00200210
00000002 0000100c 00001010 00000001 00001000 00000000
00000003 00001000 00000000 00000000 00000000 00000000
00000002 0000100c 00001010 00000000 00000000 00000000
00000006 00000000 00000000 00000000 01040517 00200210
00000004 00000000 00000000 00000000 0000100c 00001010
00000003 00002000 00000000 00000000 00000000 00000000
00000002 00002000 00002004 00000000 00000000 00000000
00000003 00003000 00000000 00000000 00000000 00000000
00000002 00003000 00003004 00000000 00000000 00000000
00000002 00001008 0000100c 00000001 00001000 00000000
00000004 00000000 00000000 00000001 00002000 00002004
00000004 00000000 00000000 00000000 00003000 00003004
00000002 00002000 00002004 00000000 00000000 00000000
00000002 00002004 00002008 00000000 00000000 00000000
00000002 00003008 0000300c 00000000 00000000 00000000
00000002 0000200c 00002010 00000000 00000000 00000000
00000002 0000300c 00003010 00000002 00000000 00000000
00000006 00000000 00000000 00000004 01040517 00200210
00000004 00000000 00000000 00000001 00002000 00002004
00000004 00000000 00000000 00000001 00002004 00002008
00000004 00000000 00000000 00000000 00003008 0000300c
00000004 00000000 00000000 00000001 0000200c 00002010
00000005 00000000 00000000 00000000 00000000 00000000
00000001 00800420 00000000 00000000 02050516 00800420
00000002 0000201c 00002020 00000001 00002000 00000000
00000001 00800320 00000000 00000010 02050516 00800420
0000000f 00000000 00000000 00000000 00000000 00000000

// ==== list.f ====
common/build_config_pkg.sv
common/fetch_pkg.sv
design/cfg_builder.sv
icache/icache_tags.sv
ibuf/inst_buffer.sv
design/fetch_top.sv
verification/fetch_top_props.sv
verification/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fetch_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Regression failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
